/* verilog/arb_pkg.sv */
`default_nettype none

package arb_pkg;

  // Requesters on the shared bus
  localparam int n_masters = 4;

  // Width of a requester index
  localparam int idx_w = $clog2(n_masters);

  // Scheme code as seen on the arb_type port
  // Codes 6 and 7 are not listed and grant nobody
  typedef enum logic [2:0] {
    arb_p0   = 3'd0,
    arb_p1   = 3'd1,
    arb_p2   = 3'd2,
    arb_p3   = 3'd3,
    arb_rr   = 3'd4,
    arb_rand = 3'd5
  } arb_scheme_e;

  // One-hot owner vector, zero when the bus is free
  typedef logic [n_masters-1:0] grant_t;

  // LFSR state is {s3, s2, s1}
  // Start with s1 set so the sequence never locks up at zero
  localparam logic [2:0] lfsr_reset = 3'b001;

endpackage : arb_pkg

`default_nettype wire

/* verilog/wb_pkg.sv */
`default_nettype none

package wb_pkg;

  // Word address, data and byte select widths
  localparam int wb_adr_w = 8;
  localparam int wb_dat_w = 32;
  localparam int wb_sel_w = 4;

  // One byte lane per select bit
  localparam int wb_lane_w = wb_dat_w / wb_sel_w;

  // Depth of the memory target in words
  localparam int mem_words = 256;

  // Master to slave signals of a classic cycle
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [wb_adr_w-1:0] adr;
    logic [wb_dat_w-1:0] dat;
    logic [wb_sel_w-1:0] sel;
  } wb_m2s_t;

  // Slave to master signals
  typedef struct packed {
    logic                ack;
    logic [wb_dat_w-1:0] dat;
  } wb_s2m_t;

  // Nothing requested
  localparam wb_m2s_t wb_m2s_idle = '0;

  // No acknowledge and read data zero
  localparam wb_s2m_t wb_s2m_idle = '0;

endpackage : wb_pkg

`default_nettype wire

/* verilog/pn_seq_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module pn_seq_gen (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       advance,
  output logic [1:0] rand_sel
);

  import arb_pkg::*;

  // Stages held as {s3, s2, s1}
  logic [2:0] lfsr_q;
  logic       feedback;

  // Feedback taps on s1 and s3
  assign feedback = lfsr_q[0] ^ lfsr_q[2];

  // Moves only on a grant decision, so idle cycles leave it alone
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr_q <= lfsr_reset;
    end else if (advance) begin
      lfsr_q <= {lfsr_q[1], lfsr_q[0], feedback};
    end
  end

  // Seed is {s3, s2}
  assign rand_sel = lfsr_q[2:1];

endmodule : pn_seq_gen

`default_nettype wire

/* verilog/bus_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [arb_pkg::n_masters-1:0] req,
  input  arb_pkg::arb_scheme_e          arb_type,
  output arb_pkg::grant_t               grant
);

  import arb_pkg::*;

  grant_t           grant_q;
  grant_t           cand;
  logic [idx_w-1:0] rr_ptr;
  logic [idx_w-1:0] rand_sel;
  logic [idx_w-1:0] win_idx;
  logic             owner_active;
  logic             decide;
  logic             advance;

  // Requester first goes first, the rest in ascending index
  function automatic grant_t fixed_pick(input logic [n_masters-1:0] r,
                                        input logic [idx_w-1:0]     first);
    grant_t g;
    logic   found;
    g     = '0;
    found = 1'b0;
    if (r[first]) begin
      g[first] = 1'b1;
      found    = 1'b1;
    end
    for (int i = 0; i < n_masters; i++) begin
      if (!found && r[i]) begin
        g[i]  = 1'b1;
        found = 1'b1;
      end
    end
    return g;
  endfunction

  // Search starts just after the last winner and wraps back to it
  function automatic grant_t rr_pick(input logic [n_masters-1:0] r,
                                     input logic [idx_w-1:0]     ptr);
    grant_t           g;
    logic [idx_w-1:0] idx;
    logic             found;
    g     = '0;
    found = 1'b0;
    for (int k = 1; k <= n_masters; k++) begin
      idx = ptr + idx_w'(k);
      if (!found && r[idx]) begin
        g[idx] = 1'b1;
        found  = 1'b1;
      end
    end
    return g;
  endfunction

  // Index of the set bit in a one-hot vector
  function automatic logic [idx_w-1:0] onehot_idx(input grant_t g);
    logic [idx_w-1:0] idx;
    idx = '0;
    for (int i = 0; i < n_masters; i++) begin
      if (g[i]) begin
        idx = idx_w'(i);
      end
    end
    return idx;
  endfunction

  pn_seq_gen i_pn_seq_gen (
    .clk      (clk),
    .rst_n    (rst_n),
    .advance  (advance),
    .rand_sel (rand_sel)
  );

  // Candidate owner under the current scheme
  always_comb begin
    case (arb_type)
      arb_p0, arb_p1, arb_p2, arb_p3: cand = fixed_pick(req, arb_type[idx_w-1:0]);
      arb_rr:                         cand = rr_pick(req, rr_ptr);
      arb_rand:                       cand = fixed_pick(req, rand_sel);
      default:                        cand = '0;
    endcase
  end

  // Owner keeps the bus while its cyc stays high
  assign owner_active = |(grant_q & req);
  assign decide       = !owner_active;

  // One LFSR step per decision that picks somebody
  assign advance = decide & (|cand);
  assign win_idx = onehot_idx(cand);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant_q <= '0;
      rr_ptr  <= '0;
    end else if (decide) begin
      grant_q <= cand;
      if (|cand) begin
        rr_ptr <= win_idx;
      end
    end
  end

  assign grant = grant_q;

endmodule : bus_arbiter

`default_nettype wire

/* verilog/wb_master_mux.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_master_mux (
  input  arb_pkg::grant_t               grant,
  input  wb_pkg::wb_m2s_t               m_req [arb_pkg::n_masters],
  output wb_pkg::wb_s2m_t               m_rsp [arb_pkg::n_masters],
  output logic [arb_pkg::n_masters-1:0] req,
  output wb_pkg::wb_m2s_t               s_req,
  input  wb_pkg::wb_s2m_t               s_rsp
);

  import arb_pkg::*;
  import wb_pkg::*;

  // cyc lines form the request vector
  always_comb begin
    for (int i = 0; i < n_masters; i++) begin
      req[i] = m_req[i].cyc;
    end
  end

  // Owner's request to the target, idle when the bus is free
  always_comb begin
    s_req = wb_m2s_idle;
    for (int i = 0; i < n_masters; i++) begin
      if (grant[i]) begin
        s_req = m_req[i];
      end
    end
  end

  // Response reaches the owner only
  always_comb begin
    for (int i = 0; i < n_masters; i++) begin
      if (grant[i]) begin
        m_rsp[i] = s_rsp;
      end else begin
        m_rsp[i] = wb_s2m_idle;
      end
    end
  end

endmodule : wb_master_mux

`default_nettype wire

/* verilog/wb_sram_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_sram_slave (
  input  logic            clk,
  input  logic            rst_n,
  input  wb_pkg::wb_m2s_t s_req,
  output wb_pkg::wb_s2m_t s_rsp
);

  import wb_pkg::*;

  logic [wb_dat_w-1:0] mem [mem_words];
  logic                ack_q;
  logic [wb_dat_w-1:0] rdat_q;
  logic                access;

  // A strobe right after an ack is not served again
  assign access = s_req.cyc & s_req.stb & !ack_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Storage and read data, updated on the ack edge
  always_ff @(posedge clk) begin
    if (access) begin
      if (s_req.we) begin
        for (int b = 0; b < wb_sel_w; b++) begin
          if (s_req.sel[b]) begin
            mem[s_req.adr][b*wb_lane_w +: wb_lane_w] <= s_req.dat[b*wb_lane_w +: wb_lane_w];
          end
        end
      end
      // Old word on a write, nobody reads it then
      rdat_q <= mem[s_req.adr];
    end
  end

  assign s_rsp.ack = ack_q;
  assign s_rsp.dat = rdat_q;

endmodule : wb_sram_slave

`default_nettype wire

/* verilog/wb_arb_bus_top.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_arb_bus_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  arb_pkg::arb_scheme_e arb_type,
  input  wb_pkg::wb_m2s_t      m_req [arb_pkg::n_masters],
  output wb_pkg::wb_s2m_t      m_rsp [arb_pkg::n_masters],
  output arb_pkg::grant_t      gnt
);

  import arb_pkg::*;
  import wb_pkg::*;

  logic [n_masters-1:0] req;
  wb_m2s_t              s_req;
  wb_s2m_t              s_rsp;

  // Grant register, also the gnt port
  bus_arbiter i_bus_arbiter (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .arb_type (arb_type),
    .grant    (gnt)
  );

  wb_master_mux i_wb_master_mux (
    .grant (gnt),
    .m_req (m_req),
    .m_rsp (m_rsp),
    .req   (req),
    .s_req (s_req),
    .s_rsp (s_rsp)
  );

  // Single memory target
  wb_sram_slave i_wb_sram_slave (
    .clk   (clk),
    .rst_n (rst_n),
    .s_req (s_req),
    .s_rsp (s_rsp)
  );

endmodule : wb_arb_bus_top

`default_nettype wire

/* sim/tb_wb_arb_bus_tasks.svh */
task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string msg);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("FAIL %0t: %s, got %0h expected %0h", $time, msg, got, exp);
  end
endtask

task automatic apply_reset();
  rst_n = 1'b0;
  repeat (reset_cycles) @(posedge clk);
  #2;
  rst_n = 1'b1;
endtask

function automatic logic [1:0] index_of(input grant_t g);
  logic [1:0] idx;
  idx = 2'd0;
  for (int i = 0; i < n_masters; i++) begin
    if (g[i]) idx = 2'(i);
  end
  return idx;
endfunction

// Fixed order picks the first requester or else the lowest pending index
function automatic grant_t expect_fixed(input logic [3:0] pending, input logic [1:0] first);
  if (pending[first]) return grant_t'(4'b0001 << first);
  for (int i = 0; i < n_masters; i++) begin
    if (pending[i]) return grant_t'(4'b0001 << i);
  end
  return '0;
endfunction

// Round robin takes the next pending index after the pointer and wraps
function automatic grant_t expect_rr(input logic [3:0] pending, input logic [1:0] ptr);
  logic [1:0] idx;
  for (int k = 1; k <= n_masters; k++) begin
    idx = 2'(ptr + 2'(k));
    if (pending[idx]) return grant_t'(4'b0001 << idx);
  end
  return '0;
endfunction

// Called and returns at edge plus 2 ns
task automatic transfer(input int m, input logic we, input logic [7:0] adr,
                        input logic [31:0] wdat, input logic hold,
                        output logic [31:0] rdat, output int cycles);
  m_req[m].cyc = 1'b1;
  m_req[m].stb = 1'b1;
  m_req[m].we  = we;
  m_req[m].adr = adr;
  m_req[m].dat = wdat;
  m_req[m].sel = 4'hf;
  cycles = 0;
  do begin
    @(posedge clk);
    #1;
    cycles++;
  end while (!m_rsp[m].ack);
  rdat = m_rsp[m].dat;
  #1;
  m_req[m].stb = 1'b0;
  m_req[m].we  = 1'b0;
  if (!hold) m_req[m].cyc = 1'b0;
  @(posedge clk);
  #2;
endtask

task automatic write_word(input int m, input logic [7:0] adr, input logic hold);
  logic [31:0] wdat;
  logic [31:0] rdat;
  int          cycles;
  wdat = $urandom;
  exp_mem[adr] = wdat;
  transfer(m, 1'b1, adr, wdat, hold, rdat, cycles);
endtask

task automatic read_word(input int m, input logic [7:0] adr);
  logic [31:0] rdat;
  int          cycles;
  transfer(m, 1'b0, adr, 32'd0, 1'b0, rdat, cycles);
  check_val(rdat, exp_mem[adr], $sformatf("master %0d read at %0h", m, adr));
endtask

task automatic all_write(input logic [7:0] base);
  fork
    write_word(0, base, 1'b0);
    write_word(1, 8'(base + 8'd1), 1'b0);
    write_word(2, 8'(base + 8'd2), 1'b0);
    write_word(3, 8'(base + 8'd3), 1'b0);
  join
endtask

task automatic all_read(input logic [7:0] base);
  fork
    read_word(0, base);
    read_word(1, 8'(base + 8'd1));
    read_word(2, 8'(base + 8'd2));
    read_word(3, 8'(base + 8'd3));
  join
endtask

task automatic reset_and_single_transfer();
  logic [7:0]  adr;
  logic [31:0] wdat;
  logic [31:0] rdat;
  int          cycles;
  check_val(32'(gnt), 32'd0, "gnt after reset");
  for (int i = 0; i < n_masters; i++) begin
    check_val(32'(m_rsp[i].ack), 32'd0, "ack after reset");
  end
  adr  = 8'($urandom);
  wdat = $urandom;
  exp_mem[adr] = wdat;
  transfer(2, 1'b1, adr, wdat, 1'b0, rdat, cycles);
  check_val(32'(cycles), 32'd2, "write latency on a free bus");
  transfer(2, 1'b0, adr, 32'd0, 1'b0, rdat, cycles);
  check_val(32'(cycles), 32'd2, "read latency on a free bus");
  check_val(rdat, wdat, "single read back");
endtask

task automatic fixed_priority_order();
  logic [3:0] pending;
  logic [7:0] base;
  grant_t     exp;
  for (int k = 0; k < 4; k++) begin
    arb_type = arb_scheme_e'(3'(k));
    base     = 8'($urandom) & 8'hfc;
    gnt_q.delete();
    seed_q.delete();
    ptr_q.delete();
    all_write(base);
    check_val(32'(gnt_q.size()), 32'd4, $sformatf("decisions under scheme %0d", k));
    pending = 4'b1111;
    foreach (gnt_q[i]) begin
      exp = expect_fixed(pending, 2'(k));
      check_val(32'(gnt_q[i]), 32'(exp), $sformatf("fixed %0d grant %0d", k, i));
      pending = pending & ~gnt_q[i];
    end
    all_read(base);
  end
endtask

task automatic round_robin_order();
  logic [3:0] pending;
  grant_t     exp;
  arb_type = arb_rr;
  gnt_q.delete();
  ptr_q.delete();
  seed_q.delete();
  all_write(8'h40);
  all_write(8'h44);
  check_val(32'(gnt_q.size()), 32'd8, "round robin decisions");
  check_val(32'(gnt_q[0]), 32'b0010, "first round robin winner");
  foreach (gnt_q[i]) begin
    if (i % 4 == 0) pending = 4'b1111;
    exp = expect_rr(pending, ptr_q[i]);
    check_val(32'(gnt_q[i]), 32'(exp), $sformatf("round robin grant %0d", i));
    pending = pending & ~gnt_q[i];
  end
  gnt_q.delete();
  seed_q.delete();
  ptr_q.delete();
  fork
    begin
      for (int n = 0; n < 3; n++) write_word(0, 8'(8'h50 + 8'(n)), 1'b0);
    end
    begin
      for (int n = 0; n < 3; n++) write_word(2, 8'(8'h60 + 8'(n)), 1'b0);
    end
  join
  check_val(32'(gnt_q.size()), 32'd6, "two master decisions");
  foreach (gnt_q[i]) begin
    // The previous owner has dropped cyc and only the other master waits
    if (i == 0) begin
      pending = 4'b0101;
    end else begin
      pending = 4'b0101 & ~gnt_q[i-1];
    end
    exp = expect_rr(pending, ptr_q[i]);
    check_val(32'(gnt_q[i]), 32'(exp), $sformatf("masters 0 and 2 grant %0d", i));
  end
endtask

task automatic random_order();
  logic [3:0] pending;
  grant_t     exp;
  arb_type = arb_rand;
  for (int r = 0; r < 2; r++) begin
    gnt_q.delete();
    seed_q.delete();
    ptr_q.delete();
    all_write(8'(8'h80 + 8'(4 * r)));
    check_val(32'(gnt_q.size()), 32'd4, "random decisions");
    pending = 4'b1111;
    foreach (gnt_q[i]) begin
      exp = expect_fixed(pending, seed_q[i]);
      check_val(32'(gnt_q[i]), 32'(exp), $sformatf("random grant %0d", i));
      pending = pending & ~gnt_q[i];
    end
  end
  all_read(8'h80);
endtask

task automatic bus_lock_and_invalid_scheme();
  arb_type = arb_p0;
  gnt_q.delete();
  seed_q.delete();
  ptr_q.delete();
  fork
    begin
      write_word(1, 8'ha0, 1'b1);
      write_word(1, 8'ha1, 1'b1);
      write_word(1, 8'ha2, 1'b0);
    end
    begin
      @(posedge clk);
      #2;
      fork
        write_word(0, 8'hb0, 1'b0);
        write_word(2, 8'hb2, 1'b0);
        write_word(3, 8'hb3, 1'b0);
      join
    end
  join
  check_val(32'(gnt_q.size()), 32'd4, "decisions around a locked bus");
  check_val(32'(gnt_q[0]), 32'b0010, "lock owner");
  check_val(32'(gnt_q[1]), 32'b0001, "first after release");
  check_val(32'(gnt_q[2]), 32'b0100, "second after release");
  check_val(32'(gnt_q[3]), 32'b1000, "third after release");
  read_word(3, 8'ha1);
  // Scheme code 6 leaves the request stalled until the scheme changes
  arb_type = arb_scheme_e'(3'd6);
  fork
    write_word(0, 8'hc0, 1'b0);
    begin
      repeat (cycles_per_xfer) begin
        @(posedge clk);
        #1;
        check_val(32'(gnt), 32'd0, "no grant under scheme 6");
        check_val(32'(m_rsp[0].ack), 32'd0, "no ack under scheme 6");
      end
      #1;
      arb_type = arb_p0;
    end
  join
  read_word(0, 8'hc0);
endtask

/* sim/tb_wb_arb_bus.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_wb_arb_bus;

  import arb_pkg::*;
  import wb_pkg::*;

  localparam int clk_period        = 40;
  localparam int reset_cycles      = 16;
  localparam int planned_transfers = 69;
  localparam int cycles_per_xfer   = 20;
  // Two resets and the stalled request window on top of the transfers
  localparam int extra_cycles      = 2 * reset_cycles + 40;
  localparam longint time_limit    =
    longint'(planned_transfers * cycles_per_xfer + extra_cycles) * clk_period;

  logic        clk;
  logic        rst_n;
  arb_scheme_e arb_type;
  wb_m2s_t     m_req [n_masters];
  wb_s2m_t     m_rsp [n_masters];
  grant_t      gnt;

  int errors;
  int checks;

  // Expected memory contents
  logic [wb_dat_w-1:0] exp_mem [mem_words];

  // Observed decisions with the model state that applied to each
  grant_t     gnt_q [$];
  logic [1:0] seed_q [$];
  logic [1:0] ptr_q [$];
  grant_t     prev_gnt;
  logic [2:0] lfsr_m;
  logic [1:0] ptr_m;

  wb_arb_bus_top i_wb_arb_bus_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .arb_type (arb_type),
    .m_req    (m_req),
    .m_rsp    (m_rsp),
    .gnt      (gnt)
  );

  always begin
    #(clk_period / 2) clk = ~clk;
  end

  `include "tb_wb_arb_bus_tasks.svh"

  // Decision monitor sampled just after each rising edge
  always begin
    @(posedge clk);
    #1;
    if (!rst_n) begin
      prev_gnt = '0;
      lfsr_m   = lfsr_reset;
      ptr_m    = 2'd0;
    end else begin
      for (int i = 0; i < n_masters; i++) begin
        if (!gnt[i]) begin
          check_val(32'(m_rsp[i].ack), 32'd0,
                    $sformatf("ack to master %0d without grant", i));
          check_val(m_rsp[i].dat, 32'd0,
                    $sformatf("read data to master %0d without grant", i));
        end
      end
      if (gnt != prev_gnt && gnt != '0) begin
        gnt_q.push_back(gnt);
        seed_q.push_back(lfsr_m[2:1]);
        ptr_q.push_back(ptr_m);
        ptr_m  = index_of(gnt);
        lfsr_m = {lfsr_m[1:0], lfsr_m[0] ^ lfsr_m[2]};
      end
      prev_gnt = gnt;
    end
  end

  initial begin
    #(time_limit);
    $display("Timeout: the tests did not finish within the time limit");
    $display("Errors found");
    $finish;
  end

  initial begin
    errors   = 0;
    checks   = 0;
    clk      = 1'b0;
    rst_n    = 1'b0;
    arb_type = arb_p0;
    for (int i = 0; i < n_masters; i++) begin
      m_req[i] = wb_m2s_idle;
    end
    void'($urandom(4));
    apply_reset();
    reset_and_single_transfer();
    fixed_priority_order();
    apply_reset();
    round_robin_order();
    random_order();
    bus_lock_and_invalid_scheme();
    repeat (4) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule : tb_wb_arb_bus

`default_nettype wire

/* arb_bus.f */
+incdir+sim
verilog/arb_pkg.sv
verilog/wb_pkg.sv
verilog/pn_seq_gen.sv
verilog/bus_arbiter.sv
verilog/wb_master_mux.sv
verilog/wb_sram_slave.sv
verilog/wb_arb_bus_top.sv
sim/tb_wb_arb_bus.sv

/* Makefile */
# Verilator build and run of the shared Wishbone bus testbench

VERILATOR ?= verilator
TOP       ?= tb_wb_arb_bus
FILELIST  ?= arb_bus.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
